/* include/cpu_params.svh */
// ****************************
// rv32i core parameters
// widths and reset values for the
// single-cycle integer core
// ****************************

`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// data and address width
`define XLEN 32

// architectural registers, x0 included
`define REG_COUNT 32

// register index width
`define REG_ADDR_W 5

// first fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

/* src/cpu_pkg.sv */
// ****************************
// rv32i core types
// opcode, alu operation and
// immediate format encodings
// ****************************

package cpu_pkg;

    // major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011
    } opcode_t;

    // alu operations
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        // operand b straight through, for lui
        ALU_PASS_B = 4'd10
    } alu_op_t;

    // immediate layouts
    typedef enum logic [2:0] {
        IMM_I = 3'd0,
        IMM_S = 3'd1,
        IMM_B = 3'd2,
        IMM_U = 3'd3,
        IMM_J = 3'd4
    } imm_type_t;

endpackage

/* src/control_unit.sv */
// ****************************
// control unit
// decodes opcode and function fields
// into datapath selects, register write
// enable and the next-pc choice
// ****************************

`timescale 1ns/1ps

module control_unit import cpu_pkg::*; (
    input  logic       [6:0] opcode,
    input  logic       [2:0] funct3,
    input  logic             funct7_b5,
    input  logic             less,
    input  logic             zero,
    output alu_op_t          alu_op,
    output imm_type_t        imm_type,
    output logic             alu_a_sel,
    output logic       [1:0] alu_b_sel,
    output logic             reg_wen,
    output logic             pc_add_sel,
    output logic             pc_base_sel,
    output logic             jalr_align
);

    opcode_t opc;
    logic    is_branch;
    logic    is_jump;
    logic    taken;

    // funct3 to alu op for op and op-imm
    function automatic alu_op_t arith_op(input logic [2:0] f3, input logic alt);
        alu_op_t op;
        case (f3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    assign opc = opcode_t'(opcode);

    always_comb begin
        // defaults: rs1 op rs2, no write, pc + 4
        alu_op      = ALU_ADD;
        imm_type    = IMM_I;
        alu_a_sel   = 1'b0;
        alu_b_sel   = 2'b00;
        reg_wen     = 1'b0;
        pc_base_sel = 1'b0;
        jalr_align  = 1'b0;
        is_branch   = 1'b0;
        is_jump     = 1'b0;
        case (opc)
            OPC_OP: begin
                alu_op  = arith_op(funct3, funct7_b5);
                reg_wen = 1'b1;
            end
            OPC_OP_IMM: begin
                // bit 30 is part of the immediate except for srai
                alu_op    = arith_op(funct3, funct7_b5 && (funct3 == 3'b101));
                alu_b_sel = 2'b01;
                reg_wen   = 1'b1;
            end
            OPC_LUI: begin
                imm_type  = IMM_U;
                alu_op    = ALU_PASS_B;
                alu_b_sel = 2'b01;
                reg_wen   = 1'b1;
            end
            OPC_AUIPC: begin
                imm_type  = IMM_U;
                alu_a_sel = 1'b1;
                alu_b_sel = 2'b01;
                reg_wen   = 1'b1;
            end
            OPC_JAL: begin
                // link value pc + 4 through the alu
                imm_type  = IMM_J;
                alu_a_sel = 1'b1;
                alu_b_sel = 2'b10;
                reg_wen   = 1'b1;
                is_jump   = 1'b1;
            end
            OPC_JALR: begin
                // target from rs1 + imm, bit 0 dropped
                imm_type    = IMM_I;
                alu_a_sel   = 1'b1;
                alu_b_sel   = 2'b10;
                reg_wen     = 1'b1;
                is_jump     = 1'b1;
                pc_base_sel = 1'b1;
                jalr_align  = 1'b1;
            end
            OPC_BRANCH: begin
                imm_type  = IMM_B;
                is_branch = 1'b1;
                // compare rs1 against rs2
                case (funct3[2:1])
                    2'b10:   alu_op = ALU_SLT;
                    2'b11:   alu_op = ALU_SLTU;
                    default: alu_op = ALU_SUB;
                endcase
            end
            default: ;
        endcase
    end

    // branch condition from alu flags
    always_comb begin
        case (funct3)
            3'b000:         taken = zero;
            3'b001:         taken = !zero;
            3'b100, 3'b110: taken = less;
            3'b101, 3'b111: taken = !less;
            default:        taken = 1'b0;
        endcase
    end

    // immediate offset on jumps and taken branches
    assign pc_add_sel = is_jump || (is_branch && taken);

endmodule

/* src/imm_decoder.sv */
// ****************************
// immediate decoder
// gathers and sign-extends the
// immediate of each rv32i format
// ****************************

`timescale 1ns/1ps
`include "cpu_params.svh"

module imm_decoder import cpu_pkg::*; (
    input  logic      [`XLEN-1:0] instr,
    input  imm_type_t             imm_type,
    output logic      [`XLEN-1:0] imm
);

    always_comb begin
        case (imm_type)
            IMM_I: begin
                imm = {{20{instr[31]}}, instr[31:20]};
            end
            IMM_S: begin
                // split around rd field
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            IMM_B: begin
                // bit 11 sits at instr[7], lsb always zero
                imm = {{19{instr[31]}}, instr[31], instr[7],
                       instr[30:25], instr[11:8], 1'b0};
            end
            IMM_U: begin
                // upper 20 bits, low bits zero
                imm = {instr[31:12], 12'b0};
            end
            IMM_J: begin
                imm = {{11{instr[31]}}, instr[31], instr[19:12],
                       instr[20], instr[30:21], 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

/* src/register_file.sv */
// ****************************
// register file
// 32 entries, two async read ports
// one sync write port, x0 reads zero
// ****************************

`timescale 1ns/1ps
`include "cpu_params.svh"

module register_file (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`REG_ADDR_W-1:0] raddr_a,
    input  logic [`REG_ADDR_W-1:0] raddr_b,
    input  logic [`REG_ADDR_W-1:0] waddr,
    input  logic [`XLEN-1:0]       wdata,
    input  logic                   wen,
    output logic [`XLEN-1:0]       rdata_a,
    output logic [`XLEN-1:0]       rdata_b
);

    // x1..x31 only, x0 has no storage
    logic [`XLEN-1:0] regs [1:`REG_COUNT-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (waddr != '0)) begin
            // writes to x0 dropped here
            regs[waddr] <= wdata;
        end
    end

    // combinational reads
    assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

endmodule

/* src/alu.sv */
// ****************************
// alu
// add, sub, logic, shifts and compares
// with less-than and zero flags
// ****************************

`timescale 1ns/1ps
`include "cpu_params.svh"

module alu import cpu_pkg::*; (
    input  logic    [`XLEN-1:0] a,
    input  logic    [`XLEN-1:0] b,
    input  alu_op_t             op,
    output logic    [`XLEN-1:0] result,
    output logic                less,
    output logic                zero
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    // only the low 5 bits of b shift
    assign shamt = b[4:0];

    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            ALU_ADD:    result = a + b;
            ALU_SUB:    result = a - b;
            ALU_SLL:    result = a << shamt;
            ALU_SLT:    result = {{(`XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU:   result = {{(`XLEN-1){1'b0}}, lt_unsigned};
            ALU_XOR:    result = a ^ b;
            ALU_SRL:    result = a >> shamt;
            // arithmetic shift keeps the sign
            ALU_SRA:    result = $unsigned($signed(a) >>> shamt);
            ALU_OR:     result = a | b;
            ALU_AND:    result = a & b;
            ALU_PASS_B: result = b;
            default:    result = '0;
        endcase
    end

    // unsigned compare only for sltu and bltu/bgeu
    assign less = (op == ALU_SLTU) ? lt_unsigned : lt_signed;

    // beq/bne run a subtract, zero means equal
    assign zero = (result == '0);

endmodule

/* src/pc_unit.sv */
// ****************************
// program counter
// pc register and next-pc adder
// ****************************

`timescale 1ns/1ps
`include "cpu_params.svh"

module pc_unit (
    input  logic             clk,
    input  logic             rst,
    input  logic [`XLEN-1:0] base,
    input  logic [`XLEN-1:0] offset,
    input  logic             jalr_align,
    output logic [`XLEN-1:0] pc,
    output logic [`XLEN-1:0] next_pc
);

    logic [`XLEN-1:0] sum;

    assign sum = base + offset;

    // jalr target has bit 0 cleared
    assign next_pc = {sum[`XLEN-1:1], sum[0] & ~jalr_align};

    // one instruction per cycle, no stall
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `RESET_PC;
        end else begin
            pc <= next_pc;
        end
    end

endmodule

/* src/cpu.sv */
// ****************************
// rv32i single-cycle core
// decode, register file, alu and pc
// with operand selects, exports the
// register write-back each cycle
// ****************************

`timescale 1ns/1ps
`include "cpu_params.svh"

module cpu import cpu_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`XLEN-1:0]       instr,
    output logic [`XLEN-1:0]       pc,
    output logic                   wb_en,
    output logic [`REG_ADDR_W-1:0] wb_addr,
    output logic [`XLEN-1:0]       wb_data
);

    // instruction fields
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rd;

    logic [`XLEN-1:0] rs1_data;
    logic [`XLEN-1:0] rs2_data;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] alu_a;
    logic [`XLEN-1:0] alu_b;
    logic [`XLEN-1:0] alu_result;
    logic [`XLEN-1:0] pc_base;
    logic [`XLEN-1:0] pc_offset;

    alu_op_t    alu_op;
    imm_type_t  imm_type;
    logic       alu_a_sel;
    logic [1:0] alu_b_sel;
    logic       reg_wen;
    logic       pc_add_sel;
    logic       pc_base_sel;
    logic       jalr_align;
    logic       less;
    logic       zero;

    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rd  = instr[11:7];

    control_unit u_ctrl (
        .opcode      (instr[6:0]),
        .funct3      (instr[14:12]),
        .funct7_b5   (instr[30]),
        .less        (less),
        .zero        (zero),
        .alu_op      (alu_op),
        .imm_type    (imm_type),
        .alu_a_sel   (alu_a_sel),
        .alu_b_sel   (alu_b_sel),
        .reg_wen     (reg_wen),
        .pc_add_sel  (pc_add_sel),
        .pc_base_sel (pc_base_sel),
        .jalr_align  (jalr_align)
    );

    imm_decoder u_imm (
        .instr    (instr),
        .imm_type (imm_type),
        .imm      (imm)
    );

    register_file u_regs (
        .clk     (clk),
        .rst     (rst),
        .raddr_a (rs1),
        .raddr_b (rs2),
        .waddr   (rd),
        .wdata   (alu_result),
        .wen     (reg_wen),
        .rdata_a (rs1_data),
        .rdata_b (rs2_data)
    );

    // alu operand a: rs1 or pc
    assign alu_a = alu_a_sel ? pc : rs1_data;

    // alu operand b: rs2, immediate or 4 for link
    always_comb begin
        case (alu_b_sel)
            2'b01:   alu_b = imm;
            2'b10:   alu_b = `XLEN'd4;
            default: alu_b = rs2_data;
        endcase
    end

    alu u_alu (
        .a      (alu_a),
        .b      (alu_b),
        .op     (alu_op),
        .result (alu_result),
        .less   (less),
        .zero   (zero)
    );

    // next pc = base + offset
    assign pc_base   = pc_base_sel ? rs1_data : pc;
    assign pc_offset = pc_add_sel ? imm : `XLEN'd4;

    pc_unit u_pc (
        .clk        (clk),
        .rst        (rst),
        .base       (pc_base),
        .offset     (pc_offset),
        .jalr_align (jalr_align),
        .pc         (pc),
        .next_pc    ()
    );

    // write-back seen by the testbench
    assign wb_en   = reg_wen;
    assign wb_addr = rd;
    assign wb_data = alu_result;

endmodule

/* bench/tb_clock.sv */
// ****************************
// testbench clock
// free-running clock, 20 ns period
// ****************************

`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    // low for the first half period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

endmodule

/* bench/tb_cpu.sv */
// ****************************
// rv32i core testbench
// replays a program trace as instruction
// memory and checks pc and write-back
// of every committed instruction
// ****************************

`timescale 1ns/1ps
`include "cpu_params.svh"

module tb_cpu;

    // addi x0, x0, 0
    localparam logic [31:0] NOP = 32'h0000_0013;

    logic                   clk;
    logic                   rst;
    logic [`XLEN-1:0]       instr;
    logic [`XLEN-1:0]       pc;
    logic                   wb_en;
    logic [`REG_ADDR_W-1:0] wb_addr;
    logic [`XLEN-1:0]       wb_data;

    // trace columns with one entry per executed instruction
    logic [31:0] exp_instr [$];
    logic [31:0] exp_pc [$];
    logic [31:0] exp_en [$];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];

    int n_lines = 0;
    int cycles = 0;

    tb_clock u_clock (
        .clk (clk)
    );

    cpu DUT (
        .clk     (clk),
        .rst     (rst),
        .instr   (instr),
        .pc      (pc),
        .wb_en   (wb_en),
        .wb_addr (wb_addr),
        .wb_data (wb_data)
    );

    // compare one observed value with its trace value
    task automatic compare_value(input string what, input logic [31:0] actual,
                                 input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %0t: %s is %h, expected %h", $time, what, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // comment and blank lines fail the five-field parse and are skipped
    task automatic load_trace();
        int          fd;
        int          rc;
        string       line;
        logic [31:0] f_instr;
        logic [31:0] f_pc;
        logic [31:0] f_en;
        logic [31:0] f_addr;
        logic [31:0] f_data;
        fd = $fopen("bench/program_input.txt", "r");
        if (fd == 0) begin
            $display("TEST FAILED");
            $fatal(1, "could not open the program trace bench/program_input.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            rc = $fgets(line, fd);
            rc = $sscanf(line, "%h %h %h %h %h", f_instr, f_pc, f_en, f_addr, f_data);
            if (rc == 5) begin
                exp_instr.push_back(f_instr);
                exp_pc.push_back(f_pc);
                exp_en.push_back(f_en);
                exp_addr.push_back(f_addr);
                exp_data.push_back(f_data);
            end
        end
        $fclose(fd);
        n_lines = exp_instr.size();
    endtask

    // run limit of trace length plus a margin for reset
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > n_lines + 20) begin
            $display("TEST FAILED");
            $fatal(1, "timeout after %0d cycles, the run did not finish", cycles);
        end
    end

    initial begin
        int idx;
        rst   = 1'b1;
        instr = NOP;
        load_trace();
        if (n_lines == 0) begin
            $display("TEST FAILED");
            $fatal(1, "the program trace holds no instructions");
        end
        // two reset cycles with nop on the bus
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // first fetch comes from the reset vector
        compare_value("pc after reset", pc, `RESET_PC);
        for (idx = 0; idx < n_lines; idx++) begin
            instr = exp_instr[idx];
            // let decode settle well before the next rising edge
            #5;
            compare_value($sformatf("line %0d pc", idx), pc, exp_pc[idx]);
            compare_value($sformatf("line %0d wb_en", idx), 32'(wb_en), exp_en[idx]);
            // addr and data only mean something on a write
            if (exp_en[idx] != 32'd0) begin
                compare_value($sformatf("line %0d wb_addr", idx), 32'(wb_addr),
                              exp_addr[idx]);
                compare_value($sformatf("line %0d wb_data", idx), wb_data, exp_data[idx]);
            end
            @(negedge clk);
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule

/* bench/program_input.txt */
// columns, all hex: instr  pc  wb_en  wb_addr  wb_data
// branches commit nothing, their addr and data columns are zero
00500093 00000000 1 01 00000005
ffd00113 00000004 1 02 fffffffd
002081b3 00000008 1 03 00000002
40208233 0000000c 1 04 00000008
401152b3 00000010 1 05 ffffffff
00115333 00000014 1 06 07ffffff
001123b3 00000018 1 07 00000001
00113433 0000001c 1 08 00000000
0f014493 00000020 1 09 ffffff0d
00409513 00000024 1 0a 00000050
4044d593 00000028 1 0b fffffff0
00356633 0000002c 1 0c 00000052
00c5f6b3 00000030 1 0d 00000050
12345737 00000034 1 0e 12345000
00001797 00000038 1 0f 00001038
00708013 0000003c 1 00 0000000c
00100833 00000040 1 10 00000005
01008463 00000044 0 00 00000000
00208463 0000004c 0 00 00000000
00209463 00000050 0 00 00000000
01009463 00000058 0 00 00000000
00114463 0000005c 0 00 00000000
0020c463 00000064 0 00 00000000
0020d463 00000068 0 00 00000000
00115463 00000070 0 00 00000000
0020e463 00000074 0 00 00000000
00116463 0000007c 0 00 00000000
00117463 00000080 0 00 00000000
0020f463 00000088 0 00 00000000
00c008ef 0000008c 1 11 00000090
01588967 00000098 1 12 0000009c
411909b3 000000a4 1 13 0000000c
ff9ff06f 000000a8 1 00 000000ac
00198a13 000000a0 1 14 0000000d

/* list.f */
+incdir+include
src/cpu_pkg.sv
src/control_unit.sv
src/imm_decoder.sv
src/register_file.sv
src/alu.sv
src/pc_unit.sv
src/cpu.sv
bench/tb_clock.sv
bench/tb_cpu.sv

/* run.sh */
#!/bin/sh
# build and run the core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f list.f --top-module tb_cpu -o tb_cpu_sim

# exit status is nonzero when the testbench hits $fatal
./obj_dir/tb_cpu_sim
